//--- backend_top.f
+incdir+include
design/backend_pkg.sv
design/backend_decoder.sv
design/backend_reg_file.sv
design/backend_multiplier.sv
design/backend_issue.sv
design/backend_commit.sv
design/backend_top.sv
sim/backend_tb.sv

//--- design/backend_commit.sv
`default_nettype none

`include "backend_defines.svh"

module backend_commit import backend_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  stage_t                     ex1_i,
  input  logic                       ex1_data_valid_i,
  input  logic [`BACKEND_XLEN-1:0]   ex1_data_i,
  input  logic                       mul_resp_valid_i,
  input  logic [`BACKEND_XLEN-1:0]   mul_resp_value_i,
  output logic                       ex2_ready_o,
  output stage_t                     ex2_o,
  output logic                       ex2_data_valid_o,
  output logic [`BACKEND_XLEN-1:0]   ex2_data_o,
  output logic                       we_o,
  output logic [`BACKEND_REG_AW-1:0] waddr_o,
  output logic [`BACKEND_XLEN-1:0]   wdata_o,
  output logic                       commit_valid_o,
  output commit_t                    commit_o
);

  stage_t ex2_q;
  stage_t ex2_d;
  logic   retire;

  // Result of the EX2 slot
  assign ex2_data_valid_o = (ex2_q.select == FU_ALU) || mul_resp_valid_i;
  assign ex2_data_o       = (ex2_q.select == FU_ALU) ? ex2_q.alu_data : mul_resp_value_i;

  assign retire      = ex2_q.pending && ex2_data_valid_o;
  assign ex2_ready_o = !ex2_q.pending || ex2_data_valid_o;

  always_comb begin
    ex2_d = ex2_q;
    if (retire) begin
      ex2_d.pending = 1'b0;
    end
    if (ex1_i.pending && ex2_ready_o) begin
      ex2_d = ex1_i;
      // Resolved data moves on as an ALU slot
      if (ex1_data_valid_i) begin
        ex2_d.select   = FU_ALU;
        ex2_d.alu_data = ex1_data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex2_q <= '0;
    end else begin
      ex2_q <= ex2_d;
    end
  end

  assign ex2_o = ex2_q;

  // Write-back and commit port
  assign we_o    = retire && ex2_q.use_rd;
  assign waddr_o = ex2_q.rd;
  assign wdata_o = ex2_data_o;

  assign commit_valid_o  = retire;
  assign commit_o.rd     = ex2_q.rd;
  assign commit_o.use_rd = ex2_q.use_rd;
  assign commit_o.data   = ex2_data_o;

endmodule

`default_nettype wire

//--- design/backend_decoder.sv
`default_nettype none

`include "backend_defines.svh"

module backend_decoder import backend_pkg::*; (
  input  logic [31:0]    instr_i,
  output decoded_instr_t decoded_o
);

  // Major opcodes of the kept instructions
  localparam logic [6:0] OpcodeOp    = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm = 7'b0010011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    decoded_o.op     = OP_ILLEGAL;
    decoded_o.rd     = instr_i[11:7];
    decoded_o.rs1    = instr_i[19:15];
    decoded_o.rs2    = instr_i[24:20];
    decoded_o.use_rd = 1'b0;
    decoded_o.imm    = {{(`BACKEND_XLEN - 12){instr_i[31]}}, instr_i[31:20]};

    case (opcode)
      OpcodeOp: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: decoded_o.op = OP_ADD;
          {7'b0100000, 3'b000}: decoded_o.op = OP_SUB;
          {7'b0000000, 3'b111}: decoded_o.op = OP_AND;
          {7'b0000000, 3'b110}: decoded_o.op = OP_OR;
          {7'b0000000, 3'b100}: decoded_o.op = OP_XOR;
          {7'b0000001, 3'b000}: decoded_o.op = OP_MUL;
          default: ;
        endcase
      end
      OpcodeOpImm: begin
        if (funct3 == 3'b000) begin
          decoded_o.op = OP_ADDI;
        end
      end
      default: ;
    endcase

    // Immediate bits sit in the rs2 field, so no rs2 dependency
    if (decoded_o.op == OP_ADDI) begin
      decoded_o.rs2 = '0;
    end

    // Illegal words read and write nothing
    if (decoded_o.op == OP_ILLEGAL) begin
      decoded_o.rd  = '0;
      decoded_o.rs1 = '0;
      decoded_o.rs2 = '0;
    end else begin
      decoded_o.use_rd = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/backend_issue.sv
`default_nettype none

`include "backend_defines.svh"

module backend_issue import backend_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  decoded_instr_t             decoded_i,
  output logic [`BACKEND_REG_AW-1:0] raddr_a_o,
  output logic [`BACKEND_REG_AW-1:0] raddr_b_o,
  input  logic [`BACKEND_XLEN-1:0]   rdata_a_i,
  input  logic [`BACKEND_XLEN-1:0]   rdata_b_i,
  output logic                       mul_req_valid_o,
  input  logic                       mul_req_ready_i,
  output logic [`BACKEND_XLEN-1:0]   mul_operand_a_o,
  output logic [`BACKEND_XLEN-1:0]   mul_operand_b_o,
  input  logic                       mul_resp_valid_i,
  input  logic [`BACKEND_XLEN-1:0]   mul_resp_value_i,
  input  logic                       ex2_ready_i,
  input  stage_t                     ex2_i,
  input  logic                       ex2_data_valid_i,
  input  logic [`BACKEND_XLEN-1:0]   ex2_data_i,
  output stage_t                     ex1_o,
  output logic                       ex1_data_valid_o,
  output logic [`BACKEND_XLEN-1:0]   ex1_data_o
);

  ////////////////////
  // Decode register
  ////////////////////

  logic           de_valid_q;
  decoded_instr_t de_q;
  logic           de_load;
  logic           issue;

  assign de_load       = fetch_valid_i && fetch_ready_o;
  assign fetch_ready_o = !de_valid_q || issue;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      de_valid_q <= 1'b0;
      de_q       <= '0;
    end else if (de_load) begin
      de_valid_q <= 1'b1;
      de_q       <= decoded_i;
    end else if (issue) begin
      de_valid_q <= 1'b0;
    end
  end

  // Register file captures these, data returns while the word sits in decode
  assign raddr_a_o = de_load ? decoded_i.rs1 : de_q.rs1;
  assign raddr_b_o = de_load ? decoded_i.rs2 : de_q.rs2;

  ////////////////////
  // Forwarding and hazards
  ////////////////////

  stage_t                     ex1_q;
  logic [`BACKEND_REG_AW-1:0] src_addr  [2];
  logic [`BACKEND_XLEN-1:0]   src_rdata [2];
  logic [`BACKEND_XLEN-1:0]   src_fwd   [2];
  logic [1:0]                 src_hazard;
  logic                       data_hazard;
  logic                       struct_hazard;

  assign src_addr[0]  = de_q.rs1;
  assign src_addr[1]  = de_q.rs2;
  assign src_rdata[0] = rdata_a_i;
  assign src_rdata[1] = rdata_b_i;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      src_fwd[i]    = src_rdata[i];
      src_hazard[i] = 1'b0;
      if (ex2_i.pending && ex2_i.use_rd && ex2_i.rd == src_addr[i] && src_addr[i] != '0) begin
        src_fwd[i]    = ex2_data_i;
        src_hazard[i] = !ex2_data_valid_i;
      end
      // EX1 is younger and wins
      if (ex1_q.pending && ex1_q.use_rd && ex1_q.rd == src_addr[i] && src_addr[i] != '0) begin
        src_fwd[i]    = ex1_data_o;
        src_hazard[i] = !ex1_data_valid_o;
      end
    end
  end

  assign data_hazard   = |src_hazard;
  assign struct_hazard = (ex1_q.pending && !ex2_ready_i) ||
                         (de_q.op == OP_MUL && !mul_req_ready_i);
  assign issue         = de_valid_q && !data_hazard && !struct_hazard;

  assign mul_req_valid_o = issue && de_q.op == OP_MUL;
  assign mul_operand_a_o = src_fwd[0];
  assign mul_operand_b_o = src_fwd[1];

  // ALU
  logic [`BACKEND_XLEN-1:0] alu_result;

  always_comb begin
    case (de_q.op)
      OP_ADD:  alu_result = src_fwd[0] + src_fwd[1];
      OP_SUB:  alu_result = src_fwd[0] - src_fwd[1];
      OP_AND:  alu_result = src_fwd[0] & src_fwd[1];
      OP_OR:   alu_result = src_fwd[0] | src_fwd[1];
      OP_XOR:  alu_result = src_fwd[0] ^ src_fwd[1];
      OP_ADDI: alu_result = src_fwd[0] + de_q.imm;
      default: alu_result = '0;
    endcase
  end

  ////////////////////
  // EX1 stage
  ////////////////////

  stage_t ex1_d;

  // A response while EX2 still waits on the multiplier belongs to EX2
  always_comb begin
    if (ex1_q.select == FU_ALU) begin
      ex1_data_valid_o = 1'b1;
      ex1_data_o       = ex1_q.alu_data;
    end else begin
      ex1_data_valid_o = mul_resp_valid_i && !(ex2_i.pending && ex2_i.select == FU_MUL);
      ex1_data_o       = mul_resp_value_i;
    end
  end

  always_comb begin
    ex1_d = ex1_q;
    // Keep a product that arrives while EX1 is stuck
    if (ex1_data_valid_o) begin
      ex1_d.select   = FU_ALU;
      ex1_d.alu_data = ex1_data_o;
    end
    if (ex2_ready_i) begin
      ex1_d.pending = 1'b0;
    end
    if (issue) begin
      ex1_d.pending  = 1'b1;
      ex1_d.select   = (de_q.op == OP_MUL) ? FU_MUL : FU_ALU;
      ex1_d.use_rd   = de_q.use_rd;
      ex1_d.rd       = de_q.rd;
      ex1_d.alu_data = alu_result;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_q <= '0;
    end else begin
      ex1_q <= ex1_d;
    end
  end

  assign ex1_o = ex1_q;

  // A slot blocked by EX2 survives into the next cycle untouched
  ex1_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ex1_q.pending && !ex2_ready_i) |=> (ex1_q.pending && $stable(ex1_q.rd) &&
                                         $stable(ex1_q.use_rd)));

endmodule

`default_nettype wire

//--- design/backend_multiplier.sv
`default_nettype none

`include "backend_defines.svh"

module backend_multiplier (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic [`BACKEND_XLEN-1:0] operand_a_i,
  input  logic [`BACKEND_XLEN-1:0] operand_b_i,
  output logic                     resp_valid_o,
  output logic [`BACKEND_XLEN-1:0] resp_value_o
);

  // Multiplier bits consumed per cycle
  localparam int unsigned StepBits = `BACKEND_XLEN / `BACKEND_MUL_CYCLES;
  localparam int unsigned CntW     = $clog2(`BACKEND_MUL_CYCLES + 1);

  logic                     busy_q;
  logic [CntW-1:0]          cnt_q;
  logic [`BACKEND_XLEN-1:0] mcand_q;
  logic [`BACKEND_XLEN-1:0] mplier_q;
  logic [`BACKEND_XLEN-1:0] acc_q;
  logic                     req_fire;
  logic [`BACKEND_XLEN-1:0] step_a;
  logic [`BACKEND_XLEN-1:0] step_b;
  logic [`BACKEND_XLEN-1:0] partial;

  assign req_ready_o  = !busy_q;
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_valid_o = busy_q && cnt_q == CntW'(`BACKEND_MUL_CYCLES);
  assign resp_value_o = acc_q;

  // First step runs on the request operands
  assign step_a = busy_q ? mcand_q : operand_a_i;
  assign step_b = busy_q ? mplier_q : operand_b_i;

  always_comb begin
    partial = '0;
    for (int i = 0; i < StepBits; i++) begin
      if (step_b[i]) begin
        partial = partial + (step_a << i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (req_fire) begin
      busy_q <= 1'b1;
      cnt_q  <= CntW'(1);
    end else if (resp_valid_o) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      acc_q    <= partial;
      mcand_q  <= operand_a_i << StepBits;
      mplier_q <= operand_b_i >> StepBits;
    end else if (busy_q && !resp_valid_o) begin
      acc_q    <= acc_q + partial;
      mcand_q  <= mcand_q << StepBits;
      mplier_q <= mplier_q >> StepBits;
    end
  end

  // The requester holds a MUL back while a product is still in flight
  no_accept_busy_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> !req_valid_i);

endmodule

`default_nettype wire

//--- design/backend_pkg.sv
`default_nettype none

`include "backend_defines.svh"

package backend_pkg;

  // Operations of the supported RISC-V subset
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_MUL,
    OP_ILLEGAL
  } op_e;

  // Source of an execute slot's result
  typedef enum logic {
    FU_ALU,
    FU_MUL
  } func_unit_e;

  // Output of the decoder
  typedef struct packed {
    op_e                        op;
    logic [`BACKEND_REG_AW-1:0] rd;
    logic [`BACKEND_REG_AW-1:0] rs1;
    logic [`BACKEND_REG_AW-1:0] rs2;
    logic                       use_rd;
    logic [`BACKEND_XLEN-1:0]   imm;
  } decoded_instr_t;

  // One slot of EX1 or EX2
  typedef struct packed {
    logic                       pending;
    func_unit_e                 select;
    logic                       use_rd;
    logic [`BACKEND_REG_AW-1:0] rd;
    // Only meaningful while select is FU_ALU
    logic [`BACKEND_XLEN-1:0]   alu_data;
  } stage_t;

  // Retired instruction as seen on the commit port
  typedef struct packed {
    logic [`BACKEND_REG_AW-1:0] rd;
    logic                       use_rd;
    logic [`BACKEND_XLEN-1:0]   data;
  } commit_t;

endpackage

`default_nettype wire

//--- design/backend_reg_file.sv
`default_nettype none

`include "backend_defines.svh"

module backend_reg_file (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [`BACKEND_REG_AW-1:0] raddr_a_i,
  input  logic [`BACKEND_REG_AW-1:0] raddr_b_i,
  output logic [`BACKEND_XLEN-1:0]   rdata_a_o,
  output logic [`BACKEND_XLEN-1:0]   rdata_b_o,
  input  logic                       we_i,
  input  logic [`BACKEND_REG_AW-1:0] waddr_i,
  input  logic [`BACKEND_XLEN-1:0]   wdata_i
);

  logic [`BACKEND_XLEN-1:0]   regs_q [`BACKEND_REG_NUM];
  logic [`BACKEND_REG_AW-1:0] raddr_a_q;
  logic [`BACKEND_REG_AW-1:0] raddr_b_q;

  // Addresses are captured, data comes out of the array combinationally
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      raddr_a_q <= '0;
      raddr_b_q <= '0;
    end else begin
      raddr_a_q <= raddr_a_i;
      raddr_b_q <= raddr_b_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired to zero
  assign rdata_a_o = (raddr_a_q == '0) ? '0 : regs_q[raddr_a_q];
  assign rdata_b_o = (raddr_b_q == '0) ? '0 : regs_q[raddr_b_q];

  // Commit stage must present a known destination with every write
  waddr_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

//--- design/backend_top.sv
`default_nettype none

`include "backend_defines.svh"

module backend_top import backend_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_valid_i,
  output logic        fetch_ready_o,
  input  logic [31:0] fetch_instr_i,
  output logic        commit_valid_o,
  output commit_t     commit_o
);

  decoded_instr_t             decoded;
  logic [`BACKEND_REG_AW-1:0] raddr_a;
  logic [`BACKEND_REG_AW-1:0] raddr_b;
  logic [`BACKEND_XLEN-1:0]   rdata_a;
  logic [`BACKEND_XLEN-1:0]   rdata_b;
  logic                       mul_req_valid;
  logic                       mul_req_ready;
  logic [`BACKEND_XLEN-1:0]   mul_operand_a;
  logic [`BACKEND_XLEN-1:0]   mul_operand_b;
  logic                       mul_resp_valid;
  logic [`BACKEND_XLEN-1:0]   mul_resp_value;
  stage_t                     ex1;
  logic                       ex1_data_valid;
  logic [`BACKEND_XLEN-1:0]   ex1_data;
  stage_t                     ex2;
  logic                       ex2_ready;
  logic                       ex2_data_valid;
  logic [`BACKEND_XLEN-1:0]   ex2_data;
  logic                       rf_we;
  logic [`BACKEND_REG_AW-1:0] rf_waddr;
  logic [`BACKEND_XLEN-1:0]   rf_wdata;

  backend_decoder decoder_inst (
    .instr_i   (fetch_instr_i),
    .decoded_o (decoded)
  );

  backend_reg_file reg_file_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  backend_issue issue_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_ready_o    (fetch_ready_o),
    .decoded_i        (decoded),
    .raddr_a_o        (raddr_a),
    .raddr_b_o        (raddr_b),
    .rdata_a_i        (rdata_a),
    .rdata_b_i        (rdata_b),
    .mul_req_valid_o  (mul_req_valid),
    .mul_req_ready_i  (mul_req_ready),
    .mul_operand_a_o  (mul_operand_a),
    .mul_operand_b_o  (mul_operand_b),
    .mul_resp_valid_i (mul_resp_valid),
    .mul_resp_value_i (mul_resp_value),
    .ex2_ready_i      (ex2_ready),
    .ex2_i            (ex2),
    .ex2_data_valid_i (ex2_data_valid),
    .ex2_data_i       (ex2_data),
    .ex1_o            (ex1),
    .ex1_data_valid_o (ex1_data_valid),
    .ex1_data_o       (ex1_data)
  );

  backend_multiplier multiplier_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (mul_req_valid),
    .req_ready_o  (mul_req_ready),
    .operand_a_i  (mul_operand_a),
    .operand_b_i  (mul_operand_b),
    .resp_valid_o (mul_resp_valid),
    .resp_value_o (mul_resp_value)
  );

  backend_commit commit_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ex1_i            (ex1),
    .ex1_data_valid_i (ex1_data_valid),
    .ex1_data_i       (ex1_data),
    .mul_resp_valid_i (mul_resp_valid),
    .mul_resp_value_i (mul_resp_value),
    .ex2_ready_o      (ex2_ready),
    .ex2_o            (ex2),
    .ex2_data_valid_o (ex2_data_valid),
    .ex2_data_o       (ex2_data),
    .we_o             (rf_we),
    .waddr_o          (rf_waddr),
    .wdata_o          (rf_wdata),
    .commit_valid_o   (commit_valid_o),
    .commit_o         (commit_o)
  );

endmodule

`default_nettype wire

//--- include/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

////////////////////
// Datapath sizes
////////////////////

// Integer data width
`define BACKEND_XLEN 32

// Integer register count and its address width
`define BACKEND_REG_NUM 32
`define BACKEND_REG_AW 5

////////////////////
// Multiplier timing
////////////////////

// Cycles from an accepted request to its response
`define BACKEND_MUL_CYCLES 8

`endif

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module backend_tb -f backend_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vbackend_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- sim/backend_tb.sv
`default_nettype none

`include "backend_defines.svh"

module backend_tb import backend_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumInstr      = 400;
  localparam int unsigned NumPrologue   = `BACKEND_REG_NUM - 1;
  localparam int unsigned TimeoutCycles = NumInstr * (`BACKEND_MUL_CYCLES + 4) * 2;

  // RISC-V major opcodes of the kept instructions
  localparam logic [6:0] OpcodeOp    = 7'b0110011;
  localparam logic [6:0] OpcodeOpImm = 7'b0010011;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_valid_i;
  logic        fetch_ready_o;
  logic [31:0] fetch_instr_i;
  logic        commit_valid_o;
  commit_t     commit_o;

  int                       seed;
  int unsigned              generated;
  int unsigned              accepted;
  int unsigned              retired;
  int unsigned              cycle_count;
  int unsigned              stall_cycles;
  int unsigned              mul_commits;
  int unsigned              illegal_commits;
  logic                     handshake;
  logic [`BACKEND_XLEN-1:0] model_regs [`BACKEND_REG_NUM];
  commit_t                  exp_q [$];
  op_e                      exp_op_q [$];

  backend_top backend_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_instr_i  (fetch_instr_i),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // Error reporting
  ////////////////////

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("CHECK FAILED at %0t: %s (got 0x%08h, expected 0x%08h)",
             $time, what, got, expected);
    stop_with_failure();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    stop_with_failure();
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Mostly x0..x4 so that neighbours depend on each other
  function automatic logic [4:0] pick_reg();
    int unsigned r;
    r = $unsigned($random(seed));
    if (r % 8 < 6) begin
      return 5'((r / 8) % 5);
    end
    return 5'((r / 8) % 32);
  endfunction

  // Load, bad funct7, SLTI and SYSTEM words are all outside the subset
  function automatic logic [31:0] illegal_instr();
    logic [31:0] word;
    int unsigned sel;
    word = $random(seed);
    sel  = $unsigned($random(seed)) % 4;
    case (sel)
      0: word[6:0] = 7'b0000011;
      1: begin
        word[6:0]   = OpcodeOp;
        word[31:25] = 7'b1111111;
      end
      2: begin
        word[6:0]   = OpcodeOpImm;
        word[14:12] = 3'b010;
      end
      default: word[6:0] = 7'b1110011;
    endcase
    return word;
  endfunction

  function automatic logic [31:0] next_instr();
    logic [31:0] word;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    int unsigned kind;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    imm  = 12'($random(seed));
    kind = $unsigned($random(seed)) % 16;
    if (generated < NumPrologue) begin
      // Give every register a known value with ADDI from x0
      word = {imm, 5'd0, 3'b000, 5'(generated + 1), OpcodeOpImm};
    end else begin
      case (kind)
        0, 1, 2, 14: word = {7'b0000000, rs2, rs1, 3'b000, rd, OpcodeOp};
        3, 4:        word = {7'b0100000, rs2, rs1, 3'b000, rd, OpcodeOp};
        5:           word = {7'b0000000, rs2, rs1, 3'b111, rd, OpcodeOp};
        6:           word = {7'b0000000, rs2, rs1, 3'b110, rd, OpcodeOp};
        7:           word = {7'b0000000, rs2, rs1, 3'b100, rd, OpcodeOp};
        8, 9, 10:    word = {imm, rs1, 3'b000, rd, OpcodeOpImm};
        11, 12, 13:  word = {7'b0000001, rs2, rs1, 3'b000, rd, OpcodeOp};
        default:     word = illegal_instr();
      endcase
    end
    generated++;
    return word;
  endfunction

  // A held word stays on the bus until it is taken
  task automatic drive_fetch();
    if (!fetch_valid_i || handshake) begin
      if (generated < NumInstr && $unsigned($random(seed)) % 4 != 0) begin
        fetch_valid_i <= 1'b1;
        fetch_instr_i <= next_instr();
      end else begin
        fetch_valid_i <= 1'b0;
      end
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic op_e classify(input logic [31:0] word);
    if (word[6:0] == OpcodeOpImm && word[14:12] == 3'b000) begin
      return OP_ADDI;
    end
    if (word[6:0] != OpcodeOp) begin
      return OP_ILLEGAL;
    end
    case ({word[31:25], word[14:12]})
      {7'b0000000, 3'b000}: return OP_ADD;
      {7'b0100000, 3'b000}: return OP_SUB;
      {7'b0000000, 3'b111}: return OP_AND;
      {7'b0000000, 3'b110}: return OP_OR;
      {7'b0000000, 3'b100}: return OP_XOR;
      {7'b0000001, 3'b000}: return OP_MUL;
      default:              return OP_ILLEGAL;
    endcase
  endfunction

  // Executes in program order at the moment fetch hands the word over
  task automatic model_accept(input logic [31:0] word);
    logic [`BACKEND_XLEN-1:0]   a;
    logic [`BACKEND_XLEN-1:0]   b;
    logic [`BACKEND_XLEN-1:0]   imm;
    logic [2*`BACKEND_XLEN-1:0] product;
    op_e                        op;
    commit_t                    exp;
    a          = model_regs[word[19:15]];
    b          = model_regs[word[24:20]];
    imm        = {{(`BACKEND_XLEN - 12){word[31]}}, word[31:20]};
    product    = a * b;
    op         = classify(word);
    exp.rd     = word[11:7];
    exp.use_rd = 1'b1;
    case (op)
      OP_ADD:  exp.data = a + b;
      OP_SUB:  exp.data = a - b;
      OP_AND:  exp.data = a & b;
      OP_OR:   exp.data = a | b;
      OP_XOR:  exp.data = a ^ b;
      OP_ADDI: exp.data = a + imm;
      OP_MUL:  exp.data = product[`BACKEND_XLEN-1:0];
      default: exp = '0;
    endcase
    if (exp.use_rd && exp.rd != '0) begin
      model_regs[exp.rd] = exp.data;
    end
    exp_q.push_back(exp);
    exp_op_q.push_back(op);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_commit();
    commit_t exp;
    op_e     op;
    assert (exp_q.size() != 0)
      else report_error("Commit arrived with no instruction outstanding");
    exp = exp_q.pop_front();
    op  = exp_op_q.pop_front();
    assert (commit_o.use_rd == exp.use_rd)
      else report_mismatch($sformatf("instr %0d write flag", retired),
                           32'(commit_o.use_rd), 32'(exp.use_rd));
    if (exp.use_rd) begin
      assert (commit_o.rd == exp.rd)
        else report_mismatch($sformatf("instr %0d rd", retired),
                             32'(commit_o.rd), 32'(exp.rd));
      assert (commit_o.data == exp.data)
        else report_mismatch($sformatf("instr %0d (%s) result", retired, op.name()),
                             commit_o.data, exp.data);
    end
    if (op == OP_MUL) begin
      mul_commits++;
    end
    if (op == OP_ILLEGAL) begin
      illegal_commits++;
    end
    retired++;
  endtask

  // Sampled mid-cycle, where DUT outputs have settled
  task automatic sample_cycle();
    handshake = fetch_valid_i && fetch_ready_o;
    if (commit_valid_o) begin
      check_commit();
    end
    if (fetch_valid_i && !fetch_ready_o) begin
      stall_cycles++;
    end
    if (handshake) begin
      model_accept(fetch_instr_i);
      accepted++;
    end
  endtask

  initial begin : main_flow
    seed            = 32'h856f42f1;
    generated       = 0;
    accepted        = 0;
    retired         = 0;
    stall_cycles    = 0;
    mul_commits     = 0;
    illegal_commits = 0;
    handshake       = 1'b0;
    for (int i = 0; i < `BACKEND_REG_NUM; i++) begin
      model_regs[i] = '0;
    end
    rst_ni        = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle outputs before any word is offered
    @(negedge clk_i);
    assert (!commit_valid_o)
      else report_mismatch("commit_valid_o after reset", 32'(commit_valid_o), 32'd0);
    assert (fetch_ready_o)
      else report_mismatch("fetch_ready_o after reset", 32'(fetch_ready_o), 32'd1);

    while (retired < NumInstr) begin
      @(posedge clk_i);
      drive_fetch();
      @(negedge clk_i);
      sample_cycle();
    end

    // Nothing may retire once the stream has drained
    repeat (2 * `BACKEND_MUL_CYCLES) begin
      @(negedge clk_i);
      assert (!commit_valid_o)
        else report_error("Commit arrived after all instructions had retired");
    end

    assert (accepted == NumInstr && exp_q.size() == 0)
      else report_error("Accepted and retired instruction counts disagree");
    assert (mul_commits > 0) else report_error("No MUL instruction was retired");
    assert (illegal_commits > 0) else report_error("No illegal word was retired");
    assert (stall_cycles > 0)
      else report_error("fetch_ready_o never dropped while a word was waiting");

    $display("TEST OK");
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    report_error($sformatf("Timeout after %0d cycles, commits stopped arriving (%0d of %0d)",
                           cycle_count, retired, NumInstr));
  end

endmodule

`default_nettype wire
